//--- Makefile
TOP = rect_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f files.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

//--- area_pipeline.sv
`timescale 1ns/1ps

module area_pipeline (
    input  logic            clk,
    input  logic            rst,
    pair_bus_if.sink        pairs,
    output rect_pkg::area_t max_area,
    output logic            done
);
    import rect_pkg::*;

    // stage 1 holds the absolute differences
    logic               v1;
    logic               f1;
    logic               l1;
    logic [coord_w-1:0] dx1;
    logic [coord_w-1:0] dy1;

    // stage 2 holds the inclusive sides
    logic               v2;
    logic               f2;
    logic               l2;
    logic [coord_w:0]   w2;
    logic [coord_w:0]   h2;

    // stage 3
    area_t              prod;
    logic               l3;

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            f1 <= 1'b0;
            l1 <= 1'b0;
        end else begin
            v1 <= pairs.valid;
            f1 <= pairs.first;
            l1 <= pairs.last;
        end
    end

    always_ff @(posedge clk) begin
        dx1 <= (pairs.a.x > pairs.b.x) ? pairs.a.x - pairs.b.x : pairs.b.x - pairs.a.x;
        dy1 <= (pairs.a.y > pairs.b.y) ? pairs.a.y - pairs.b.y : pairs.b.y - pairs.a.y;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v2 <= 1'b0;
            f2 <= 1'b0;
            l2 <= 1'b0;
        end else begin
            v2 <= v1;
            f2 <= f1;
            l2 <= l1;
        end
    end

    always_ff @(posedge clk) begin
        w2 <= {1'b0, dx1} + 1'b1;  // 65535 + 1 needs the extra bit
        h2 <= {1'b0, dy1} + 1'b1;
    end

    assign prod = area_t'(w2) * area_t'(h2);

    always_ff @(posedge clk) begin
        if (rst) begin
            max_area <= '0;
            l3       <= 1'b0;
        end else begin
            l3 <= l2;
            if (f2) begin
                max_area <= v2 ? prod : '0;  // new run starts from zero
            end else if (v2 && prod > max_area) begin
                max_area <= prod;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (pairs.first) begin
            done <= 1'b0;
        end else if (l3) begin
            done <= 1'b1;
        end
    end

    // no valid pair may still trail the last one when done rises
    a_done_after_last: assert property (
        @(posedge clk) disable iff (rst)
        $rose(done) |-> $past(l3) && !$past(v1) && !$past(v2)
    ) else $error("done rose without a last pair");

endmodule

//--- files.f
rect_pkg.sv
pair_bus_if.sv
point_store.sv
pair_scheduler.sv
area_pipeline.sv
rect_top.sv
rect_tb.sv

//--- pair_bus_if.sv
`timescale 1ns/1ps

interface pair_bus_if;
    import rect_pkg::*;

    logic   valid;
    logic   first;  // first pair of a run, or the empty-run marker
    logic   last;   // final pair, or the empty-run marker
    point_t a;
    point_t b;

    modport source (
        output valid,
        output first,
        output last,
        output a,
        output b
    );

    modport sink (
        input valid,
        input first,
        input last,
        input a,
        input b
    );

endinterface

//--- pair_scheduler.sv
`timescale 1ns/1ps

module pair_scheduler #(
    parameter int MAX_POINTS = 64,
    parameter int IDX_W      = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [IDX_W:0]    num_points,
    output logic              busy,
    output logic [IDX_W-1:0]  idx_i,
    output logic [IDX_W-1:0]  idx_j,
    input  rect_pkg::point_t  point_i,
    input  rect_pkg::point_t  point_j,
    pair_bus_if.source        pairs
);
    import rect_pkg::*;

    sched_state_e     state;
    logic [IDX_W:0]   n_q;       // point count latched at start
    logic [IDX_W-1:0] i_q;
    logic [IDX_W-1:0] j_q;
    logic             first_q;   // no pair issued yet in this run
    logic             end_of_row;
    logic             end_of_run;

    // flags delayed to line up with the memory read
    logic valid_d;
    logic first_d;
    logic last_d;

    logic last_seen_q;

    assign end_of_row = ({1'b0, j_q} == n_q - 1'b1);
    assign end_of_run = end_of_row && ({1'b0, i_q} == n_q - 2'd2);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            n_q     <= '0;
            i_q     <= '0;
            j_q     <= '0;
            first_q <= 1'b0;
        end else begin
            unique case (state)
                idle: begin
                    if (start) begin
                        n_q     <= num_points;
                        i_q     <= '0;
                        j_q     <= IDX_W'(1);
                        first_q <= 1'b1;
                        state   <= (num_points < 2) ? finish : fetch_i;
                    end
                end
                fetch_i: begin
                    state <= issue;
                end
                issue: begin
                    first_q <= 1'b0;
                    if (end_of_run) begin
                        state <= finish;
                    end else if (end_of_row) begin
                        i_q   <= i_q + IDX_W'(1);
                        j_q   <= i_q + IDX_W'(2);
                        state <= fetch_i;
                    end else begin
                        j_q <= j_q + IDX_W'(1);
                    end
                end
                finish: begin
                    first_q <= 1'b0;
                    state   <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d <= 1'b0;
            first_d <= 1'b0;
            last_d  <= 1'b0;
        end else begin
            valid_d <= (state == issue);
            first_d <= first_q && (state == issue || state == finish);
            // empty run still needs a marker so the pipeline can close out
            last_d  <= (state == issue && end_of_run) || (state == finish && n_q < 2);
        end
    end

    assign idx_i = i_q;
    assign idx_j = j_q;

    // held until the final bus cycle has left
    assign busy = (state != idle) || valid_d || last_d;

    assign pairs.valid = valid_d;
    assign pairs.first = first_d;
    assign pairs.last  = last_d;
    assign pairs.a     = point_i;
    assign pairs.b     = point_j;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_seen_q <= 1'b0;
        end else if (start && state == idle) begin
            last_seen_q <= 1'b0;
        end else if (last_d) begin
            last_seen_q <= 1'b1;
        end
    end

    a_upper_triangle: assert property (
        @(posedge clk) disable iff (rst)
        (state == issue) |-> (idx_j > idx_i)
    ) else $error("pair_scheduler issued j <= i");

    a_single_last: assert property (
        @(posedge clk) disable iff (rst)
        pairs.last |-> !last_seen_q
    ) else $error("pair_scheduler raised last twice in one run");

endmodule

//--- point_store.sv
`timescale 1ns/1ps

module point_store #(
    parameter int MAX_POINTS = 64,
    parameter int IDX_W      = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_en,
    input  logic [IDX_W-1:0]  load_addr,
    input  rect_pkg::point_t  load_point,
    input  logic              busy,
    input  logic [IDX_W-1:0]  idx_i,
    input  logic [IDX_W-1:0]  idx_j,
    output rect_pkg::point_t  point_i,
    output rect_pkg::point_t  point_j
);
    import rect_pkg::*;

    point_t mem [MAX_POINTS];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_point;
        end
    end

    // two read ports, one cycle latency each
    always_ff @(posedge clk) begin
        point_i <= mem[idx_i];  // outer index, held through a row
        point_j <= mem[idx_j];
    end

    // the scheduler reads the memory on every cycle of a search
    a_no_load_busy: assert property (
        @(posedge clk) disable iff (rst)
        busy |-> !load_en
    ) else $error("point_store written during a search");

endmodule

//--- rect_pkg.sv
package rect_pkg;

    // one coordinate axis
    localparam int coord_w = 16;

    // inclusive sides can reach 2^coord_w, so each side needs one extra bit
    localparam int area_w = 2 * coord_w + 2;

    typedef struct packed {
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
    } point_t;

    typedef logic [area_w-1:0] area_t;

    typedef enum logic [1:0] {
        idle,
        fetch_i,   // read the outer point
        issue,     // one pair per clock
        finish
    } sched_state_e;

endpackage

//--- rect_tb.sv
`timescale 1ns/1ps

module rect_tb;
    import rect_pkg::*;

    localparam int MAX_POINTS = 64;
    localparam int IDX_W      = $clog2(MAX_POINTS);
    localparam int N_W        = IDX_W + 1;
    localparam int NUM_CASES  = 8;
    localparam int NUM_FIXED  = 15;

    localparam logic [63:0] NO_EXP = 64'hFFFF_FFFF_FFFF_FFFF;  // expected value from model only

    // case table: point count, random source, offset into fixed_pts, hand-derived area
    localparam int case_n [NUM_CASES] = '{8, 2, 4, 0, 1, 64, 64, 64};
    localparam bit case_rand [NUM_CASES] = '{0, 0, 0, 0, 0, 1, 1, 1};
    localparam int case_off [NUM_CASES] = '{0, 8, 10, 14, 14, 0, 0, 0};
    localparam logic [63:0] case_exp [NUM_CASES] = '{
        64'd160,
        64'h0000_0001_0000_0000,  // full corners, 2^32
        64'd1,
        64'd0,
        64'd0,
        NO_EXP,
        NO_EXP,
        NO_EXP
    };

    // {x, y}
    localparam logic [31:0] fixed_pts [NUM_FIXED] = '{
        32'h0002_0005, 32'h000A_0001, 32'h0007_0007, 32'h0003_000C,
        32'h000F_0009, 32'h0000_0000, 32'h0009_000E, 32'h0004_0003,
        32'h0000_0000, 32'hFFFF_FFFF,
        32'h0064_00C8, 32'h0064_00C8, 32'h0064_00C8, 32'h0064_00C8,
        32'h01F4_0258
    };

    logic               clk;
    logic               rst;
    logic               load_en;
    logic [IDX_W-1:0]   load_addr;
    logic [coord_w-1:0] load_x;
    logic [coord_w-1:0] load_y;
    logic [N_W-1:0]     num_points;
    logic               start;
    logic [area_w-1:0]  max_area;
    logic               done;

    logic [31:0] pts [MAX_POINTS];  // points of the current case
    logic [31:0] lcg_state = 32'd69;
    int          errors = 0;

    rect_top #(
        .MAX_POINTS (MAX_POINTS)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_x     (load_x),
        .load_y     (load_y),
        .num_points (num_points),
        .start      (start),
        .max_area   (max_area),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];  // upper bits have the longer period
    endfunction

    // brute force over every unordered pair, sides counted inclusively
    function automatic logic [63:0] model_max_area(input int n);
        logic [63:0] best;
        logic [63:0] xi;
        logic [63:0] xj;
        logic [63:0] yi;
        logic [63:0] yj;
        logic [63:0] w;
        logic [63:0] h;
        best = 64'd0;
        for (int i = 0; i < n; i++) begin
            for (int j = i + 1; j < n; j++) begin
                xi = {48'd0, pts[i][31:16]};
                xj = {48'd0, pts[j][31:16]};
                yi = {48'd0, pts[i][15:0]};
                yj = {48'd0, pts[j][15:0]};
                w  = ((xi > xj) ? xi - xj : xj - xi) + 64'd1;
                h  = ((yi > yj) ? yi - yj : yj - yi) + 64'd1;
                if (w * h > best) begin
                    best = w * h;
                end
            end
        end
        return best;
    endfunction

    task automatic halt_failed();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            halt_failed();
        end
    endtask

    task automatic fill_points(input int c);
        logic [15:0] x;
        logic [15:0] y;
        for (int k = 0; k < case_n[c]; k++) begin
            if (case_rand[c]) begin
                x = lcg_next();
                y = lcg_next();
                pts[k] = {x, y};
            end else begin
                pts[k] = fixed_pts[case_off[c] + k];
            end
        end
    endtask

    task automatic load_points(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = IDX_W'(k);
            load_x    = pts[k][31:16];
            load_y    = pts[k][15:0];
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
    endtask

    task automatic run_search(input int n);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        num_points = N_W'(n);
        start      = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value("done", 64'(done), 64'd0);  // old result must be hidden now
        while (!done && waited < n * n + 50) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!done) begin
            $display("search over %0d points never raised done within %0d cycles", n, waited);
            halt_failed();
        end
    endtask

    initial begin
        logic [63:0] want;
        rst        = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_x     = '0;
        load_y     = '0;
        num_points = '0;
        start      = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        check_value("done", 64'(done), 64'd0);
        check_value("max_area", 64'(max_area), 64'd0);

        for (int c = 0; c < NUM_CASES; c++) begin
            fill_points(c);
            load_points(case_n[c]);
            want = model_max_area(case_n[c]);
            if (case_exp[c] != NO_EXP) begin
                check_value("model_area", want, case_exp[c]);
            end
            run_search(case_n[c]);
            check_value("max_area", 64'(max_area), want);
        end

        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // budget grows with the square of each point count
    initial begin
        longint budget;
        budget = 200;
        for (int c = 0; c < NUM_CASES; c++) begin
            budget += case_n[c] * case_n[c] + 4 * case_n[c] + 40;
        end
        #(budget * 8);
        $display("watchdog expired after %0d clock cycles", budget);
        $display("TEST FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- rect_top.sv
`timescale 1ns/1ps

module rect_top #(
    parameter int  MAX_POINTS = 64,
    localparam int IDX_W      = $clog2(MAX_POINTS)
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         load_en,
    input  logic [IDX_W-1:0]             load_addr,
    input  logic [rect_pkg::coord_w-1:0] load_x,
    input  logic [rect_pkg::coord_w-1:0] load_y,
    input  logic [IDX_W:0]               num_points,
    input  logic                         start,
    output logic [rect_pkg::area_w-1:0]  max_area,
    output logic                         done
);
    import rect_pkg::*;

    point_t           load_point;
    logic             busy;
    logic [IDX_W-1:0] idx_i;
    logic [IDX_W-1:0] idx_j;
    point_t           point_i;
    point_t           point_j;
    area_t            pipe_max;
    logic             pipe_done;

    pair_bus_if pairs ();

    assign load_point.x = load_x;
    assign load_point.y = load_y;

    point_store #(
        .MAX_POINTS (MAX_POINTS),
        .IDX_W      (IDX_W)
    ) u_store (
        .clk        (clk),
        .rst        (rst),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_point (load_point),
        .busy       (busy),
        .idx_i      (idx_i),
        .idx_j      (idx_j),
        .point_i    (point_i),
        .point_j    (point_j)
    );

    pair_scheduler #(
        .MAX_POINTS (MAX_POINTS),
        .IDX_W      (IDX_W)
    ) u_sched (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .num_points (num_points),
        .busy       (busy),
        .idx_i      (idx_i),
        .idx_j      (idx_j),
        .point_i    (point_i),
        .point_j    (point_j),
        .pairs      (pairs.source)
    );

    area_pipeline u_pipe (
        .clk      (clk),
        .rst      (rst),
        .pairs    (pairs.sink),
        .max_area (pipe_max),
        .done     (pipe_done)
    );

    assign max_area = pipe_max;

    // hide the previous result from the edge after start onwards
    assign done = pipe_done && !busy;

endmodule
